/* verilog.f */
source/posit_pkg.sv
source/posit_decode.sv
source/posit_add_raw.sv
source/posit_encode.sv
source/posit_adder.sv
tests/posit_adder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the posit adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module posit_adder_tb -o posit_adder_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/posit_adder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

/* tests/posit_adder_tb.sv */
// testbench for the pipelined posit adder
// random and directed additions checked against a queue by concurrent assertions
`timescale 1ns/1ps

module posit_adder_tb;

    import posit_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY = 5;
    // items per test
    localparam int N_LAT = 24;
    localparam int N_ZERO = 32;
    localparam int N_NEG = 48;
    localparam int N_NAR = 32;
    localparam int N_DBL = 48;
    localparam int N_STICKY = 21;
    localparam int TOTAL_OPS = N_LAT + 2 * N_ZERO + N_NEG + 2 * N_NAR + 1 + N_DBL + N_STICKY;
    // idle gaps, reset and pipeline drains
    localparam int MARGIN_NS = 2000;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic [NBITS-1:0] a;
    logic [NBITS-1:0] b;
    logic             out_valid;
    logic [NBITS-1:0] sum;

    logic [31:0]      seed = 32'h8390_4458;
    logic [NBITS-1:0] exp_q[$];
    int               rd_idx;
    int               errors;
    int               test_base;

    posit_adder posit_adder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .sum       (sum)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // LCG step
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // any word except NaR
    function automatic logic [NBITS-1:0] real_word();
        logic [NBITS-1:0] w;
        w = next_rand();
        if (w == NAR_WORD)
            w = ZERO_WORD;
        return w;
    endfunction

    // 2^k with regime k>>>3, exponent field k mod 8 and an empty fraction
    function automatic logic [NBITS-1:0] pow2_word(input int k);
        int               r;
        int               pos;
        logic [NBITS-1:0] w;
        r = k >>> 3;
        w = ZERO_WORD;
        pos = NBITS - 2;
        if (r >= 0)
        begin
            // r+1 ones then the zero terminator
            for (int i = 0; i <= r; i++)
            begin
                w[pos] = 1'b1;
                pos--;
            end
            pos--;
        end
        else
        begin
            // -r zeros then the one terminator
            pos = pos + r;
            w[pos] = 1'b1;
            pos--;
        end
        w[pos -: ES] = 3'(k & 7);
        return w;
    endfunction

    // one addition on the next rising edge
    task automatic issue(input logic [NBITS-1:0] x, input logic [NBITS-1:0] y,
                         input logic [NBITS-1:0] e);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // drain the pipe, then one line for the test
    task automatic end_test(input string name, input int n);
        idle_cycle();
        while (rd_idx != exp_q.size())
            @(posedge clk);
        $display("test %s: %0d additions, %0d errors", name, n, errors - test_base);
        test_base = errors;
    endtask

    // read pointer into the expected queue
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_idx <= 0;
        else if (out_valid)
            rd_idx <= rd_idx + 1;
    end

    // out_valid mirrors in_valid five cycles back, low right after reset
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, LATENCY))
    else
    begin
        errors++;
        $display("ERR %0t: out_valid did not follow in_valid by %0d cycles", $time, LATENCY);
    end

    // each result matches the oldest outstanding expected word
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (rd_idx < exp_q.size() && sum == exp_q[rd_idx]))
    else
    begin
        errors++;
        $display("ERR %0t: sum %h, expected %h", $time, $sampled(sum),
                 exp_q[$sampled(rd_idx)]);
    end

    // watchdog sized from the operation count
    initial
    begin
        #(TOTAL_OPS * CLK_PERIOD + MARGIN_NS);
        $display("timeout: results still missing after %0t ns", $time);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        logic [NBITS-1:0] x;
        int               k;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = ZERO_WORD;
        b        = ZERO_WORD;
        errors    = 0;
        test_base = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // random gaps between items
        for (int i = 0; i < N_LAT; i++)
        begin
            x = real_word();
            issue(x, ZERO_WORD, x);
            if (next_rand() & 32'h8)
                idle_cycle();
        end
        end_test("latency", N_LAT);

        // zero on either side returns x untouched
        for (int i = 0; i < N_ZERO; i++)
        begin
            x = real_word();
            issue(x, ZERO_WORD, x);
            issue(ZERO_WORD, x, x);
        end
        end_test("zero_identity", 2 * N_ZERO);

        // exact cancellation
        for (int i = 0; i < N_NEG; i++)
        begin
            x = real_word();
            issue(x, -x, ZERO_WORD);
        end
        end_test("negation", N_NEG);

        // NaR absorbs everything
        for (int i = 0; i < N_NAR; i++)
        begin
            x = next_rand();
            issue(NAR_WORD, x, NAR_WORD);
            issue(x, NAR_WORD, NAR_WORD);
        end
        issue(NAR_WORD, NAR_WORD, NAR_WORD);
        end_test("nar", 2 * N_NAR + 1);

        // doubling moves one scale step
        for (int i = 0; i < N_DBL; i++)
        begin
            k = int'(next_rand() % 201) - 100;
            issue(pow2_word(k), pow2_word(k), pow2_word(k + 1));
        end
        end_test("doubling", N_DBL);

        // tiny addend only reaches the sticky bit
        for (k = -60; k <= -40; k++)
            issue(pow2_word(0), pow2_word(k), pow2_word(0));
        end_test("sticky_round", N_STICKY);

        $display("summary: %0d additions checked, %0d errors", rd_idx, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* source/posit_adder.sv */
// pipelined 32-bit posit adder, es = 3
// decode, raw add and encode in a five cycle chain
`timescale 1ns/1ps

module posit_adder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [posit_pkg::NBITS-1:0] a,
    input  logic [posit_pkg::NBITS-1:0] b,
    output logic                        out_valid,
    output logic [posit_pkg::NBITS-1:0] sum
);

    import posit_pkg::*;

    // decode to raw adder
    logic                      dec_valid;
    posit_class_e              a_class, b_class;
    logic                      a_sign, b_sign;
    logic signed [SCALE_W-1:0] a_scale, b_scale;
    logic [FRAC_W-1:0]         a_frac, b_frac;

    // raw adder to encode
    logic                      raw_valid;
    posit_class_e              raw_class;
    logic                      raw_sign;
    logic signed [SCALE_W-1:0] raw_scale;
    logic [SUM_W-1:0]          raw_frac;
    logic                      raw_sticky;

    // 1 cycle
    posit_decode posit_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .dec_valid (dec_valid),
        .a_class   (a_class),
        .b_class   (b_class),
        .a_sign    (a_sign),
        .b_sign    (b_sign),
        .a_scale   (a_scale),
        .b_scale   (b_scale),
        .a_frac    (a_frac),
        .b_frac    (b_frac)
    );

    // 3 cycles
    posit_add_raw posit_add_raw_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .a_class    (a_class),
        .b_class    (b_class),
        .a_sign     (a_sign),
        .b_sign     (b_sign),
        .a_scale    (a_scale),
        .b_scale    (b_scale),
        .a_frac     (a_frac),
        .b_frac     (b_frac),
        .raw_valid  (raw_valid),
        .raw_class  (raw_class),
        .raw_sign   (raw_sign),
        .raw_scale  (raw_scale),
        .raw_frac   (raw_frac),
        .raw_sticky (raw_sticky)
    );

    // 1 cycle
    posit_encode posit_encode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_valid  (raw_valid),
        .raw_class  (raw_class),
        .raw_sign   (raw_sign),
        .raw_scale  (raw_scale),
        .raw_frac   (raw_frac),
        .raw_sticky (raw_sticky),
        .out_valid  (out_valid),
        .sum        (sum)
    );

endmodule

/* source/posit_encode.sv */
// posit encode stage
// packs regime, exponent and fraction, rounds to nearest even, saturates
`timescale 1ns/1ps

module posit_encode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    raw_valid,
    input  posit_pkg::posit_class_e                 raw_class,
    input  logic                                    raw_sign,
    input  logic signed [posit_pkg::SCALE_W-1:0]    raw_scale,
    input  logic [posit_pkg::SUM_W-1:0]             raw_frac,
    input  logic                                    raw_sticky,
    output logic                                    out_valid,
    output logic [posit_pkg::NBITS-1:0]             sum
);

    import posit_pkg::*;

    // regime head, exponent and fraction below the hidden bit
    localparam int EXT_W = 2 + ES + SUM_W - 1;

    logic signed [SCALE_W-ES-1:0] k;
    logic                         fill;
    logic [SCALE_W-ES-1:0]        sh;
    logic [EXT_W-1:0]             ext;
    logic [2*NBITS-1:0]           wide, wide_s;
    logic [NBITS-2:0]             body;
    logic                         guard, rest, rnd;
    logic [NBITS-1:0]             mag, word;

    always_comb
    begin
        // regime value is the scale shifted down by ES
        k    = raw_scale[SCALE_W-1:ES];
        fill = ~k[SCALE_W-ES-1];
        // k >= 0: k+1 ones then 0, k < 0: -k zeros then 1
        sh   = fill ? k : ~k;
        ext  = {fill ? 2'b10 : 2'b01, raw_scale[ES-1:0], raw_frac[SUM_W-2:0]};
        wide = {ext, {(2*NBITS - EXT_W){1'b0}}};
        // shift in the regime run
        wide_s = fill ? ~((~wide) >> sh) : (wide >> sh);
        body   = wide_s[2*NBITS-1 -: NBITS-1];
        guard  = wide_s[NBITS];
        rest   = (|wide_s[NBITS-1:0]) | raw_sticky;
        // nearest, ties to even
        rnd    = guard & (rest | body[0]);
        mag    = {1'b0, body} + NBITS'(rnd);
        // clamp to maxpos or minpos, never to zero or NaR
        if (raw_scale > MAX_SCALE || mag[NBITS-1])
            mag = {1'b0, {(NBITS - 1){1'b1}}};
        else if (raw_scale < -MAX_SCALE)
            mag = NBITS'(1);
        case (raw_class)
            CLASS_ZERO: word = ZERO_WORD;
            CLASS_NAR:  word = NAR_WORD;
            default:    word = raw_sign ? -mag : mag;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= raw_valid;
    end

    always_ff @(posedge clk)
    begin
        sum <= word;
    end

    // a real sum never collapses onto a special word
    assert property (@(posedge clk) disable iff (!rst_n)
        raw_valid && raw_class == CLASS_NUM |=> sum != ZERO_WORD && sum != NAR_WORD);

endmodule

/* source/posit_add_raw.sv */
// raw posit adder core, three pipeline stages
// orders, aligns with sticky, adds or subtracts and normalizes decoded operands
`timescale 1ns/1ps

module posit_add_raw (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    dec_valid,
    input  posit_pkg::posit_class_e                 a_class,
    input  posit_pkg::posit_class_e                 b_class,
    input  logic                                    a_sign,
    input  logic                                    b_sign,
    input  logic signed [posit_pkg::SCALE_W-1:0]    a_scale,
    input  logic signed [posit_pkg::SCALE_W-1:0]    b_scale,
    input  logic [posit_pkg::FRAC_W-1:0]            a_frac,
    input  logic [posit_pkg::FRAC_W-1:0]            b_frac,
    output logic                                    raw_valid,
    output posit_pkg::posit_class_e                 raw_class,
    output logic                                    raw_sign,
    output logic signed [posit_pkg::SCALE_W-1:0]    raw_scale,
    output logic [posit_pkg::SUM_W-1:0]             raw_frac,
    output logic                                    raw_sticky
);

    import posit_pkg::*;

    localparam int MAN_W = FRAC_W + 1;

    // stage 1 signals
    logic                       a_ge_b;
    logic [SCALE_W+FRAC_W-1:0]  a_key, b_key;
    logic signed [SCALE_W:0]    diff_w;
    logic                       s1_valid, s1_sign, s1_sub;
    posit_class_e               s1_class;
    logic signed [SCALE_W-1:0]  s1_hi_scale;
    logic [SCALE_W-1:0]         s1_diff;
    logic [MAN_W-1:0]           s1_hi_man, s1_lo_man;

    // stage 2 signals
    logic [4:0]                 align_sh;
    logic [2*MAN_W-1:0]         lo_wide;
    logic                       align_sticky;
    logic [SUM_W-1:0]           hi_al, lo_al, sum_c;
    logic [4:0]                 lz;
    logic signed [SCALE_W:0]    scale_w;
    logic                       s2_valid, s2_sign, s2_sticky;
    posit_class_e               s2_class;
    logic signed [SCALE_W-1:0]  s2_scale;
    logic [SUM_W-1:0]           s2_sum;
    logic [4:0]                 s2_lz;

    // stage 1: order by magnitude, offset scale sign so keys compare unsigned
    assign a_key  = {~a_scale[SCALE_W-1], a_scale[SCALE_W-2:0], a_frac};
    assign b_key  = {~b_scale[SCALE_W-1], b_scale[SCALE_W-2:0], b_frac};
    // zero operand always goes low
    assign a_ge_b = (b_class == CLASS_ZERO) || (a_class != CLASS_ZERO && a_key >= b_key);
    assign diff_w = a_ge_b ? (a_scale - b_scale) : (b_scale - a_scale);

    always_ff @(posedge clk)
    begin
        if (a_class == CLASS_NAR || b_class == CLASS_NAR)
            s1_class <= CLASS_NAR;
        else if (a_class == CLASS_ZERO && b_class == CLASS_ZERO)
            s1_class <= CLASS_ZERO;
        else
            s1_class <= CLASS_NUM;
        s1_sign     <= a_ge_b ? a_sign : b_sign;
        s1_sub      <= a_sign ^ b_sign;
        s1_hi_scale <= a_ge_b ? a_scale : b_scale;
        s1_diff     <= diff_w[SCALE_W-1:0];
        // hidden bit only for real numbers
        s1_hi_man   <= a_ge_b ? {a_class == CLASS_NUM, a_frac} : {b_class == CLASS_NUM, b_frac};
        s1_lo_man   <= a_ge_b ? {b_class == CLASS_NUM, b_frac} : {a_class == CLASS_NUM, a_frac};
    end

    // stage 2: align low operand, a shift of MAN_W or more leaves only sticky
    assign align_sh     = (s1_diff >= MAN_W) ? 5'(MAN_W) : s1_diff[4:0];
    assign lo_wide      = {s1_lo_man, {MAN_W{1'b0}}} >> align_sh;
    assign align_sticky = |lo_wide[MAN_W-1:0];
    // bit 0 is a slot for the sticky so subtraction borrows correctly
    assign hi_al = {1'b0, s1_hi_man, 1'b0};
    assign lo_al = {1'b0, lo_wide[2*MAN_W-1:MAN_W], align_sticky};
    assign sum_c = s1_sub ? (hi_al - lo_al) : (hi_al + lo_al);

    // leading zero count, highest one wins
    always_comb
    begin
        lz = 5'd0;
        for (int i = 0; i < SUM_W; i++)
        begin
            if (sum_c[i])
                lz = 5'(SUM_W - 1 - i);
        end
    end

    // leading one at bit SUM_W-1-lz, hidden bit sat at SUM_W-2
    assign scale_w = $signed({s1_hi_scale[SCALE_W-1], s1_hi_scale}) + 1 - $signed({5'b0, lz});

    always_ff @(posedge clk)
    begin
        // exact cancellation
        if (s1_class == CLASS_NUM && sum_c == '0)
            s2_class <= CLASS_ZERO;
        else
            s2_class <= s1_class;
        s2_sign   <= s1_sign;
        // deep cancellation can drop below the 9-bit range, encode clamps it
        s2_scale  <= (scale_w < -256) ? -9'sd256 : scale_w[SCALE_W-1:0];
        s2_sum    <= sum_c;
        s2_lz     <= lz;
        s2_sticky <= align_sticky;
    end

    // stage 3: normalize, leading one moves to the top bit
    always_ff @(posedge clk)
    begin
        raw_class  <= s2_class;
        raw_sign   <= s2_sign;
        raw_scale  <= s2_scale;
        raw_frac   <= s2_sum << s2_lz;
        raw_sticky <= s2_sticky;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            raw_valid <= 1'b0;
        end
        else
        begin
            s1_valid  <= dec_valid;
            s2_valid  <= s1_valid;
            raw_valid <= s2_valid;
        end
    end

    // normalized output for every real result
    assert property (@(posedge clk) disable iff (!rst_n)
        raw_valid && raw_class == CLASS_NUM |-> raw_frac[SUM_W-1]);

endmodule

/* source/posit_decode.sv */
// posit decode stage
// splits two posit words into class, sign, scale and left-aligned fraction
`timescale 1ns/1ps

module posit_decode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic [posit_pkg::NBITS-1:0]             a,
    input  logic [posit_pkg::NBITS-1:0]             b,
    output logic                                    dec_valid,
    output posit_pkg::posit_class_e                 a_class,
    output posit_pkg::posit_class_e                 b_class,
    output logic                                    a_sign,
    output logic                                    b_sign,
    output logic signed [posit_pkg::SCALE_W-1:0]    a_scale,
    output logic signed [posit_pkg::SCALE_W-1:0]    b_scale,
    output logic [posit_pkg::FRAC_W-1:0]            a_frac,
    output logic [posit_pkg::FRAC_W-1:0]            b_frac
);

    import posit_pkg::*;

    posit_class_e              a_class_c, b_class_c;
    logic                      a_sign_c, b_sign_c;
    logic signed [SCALE_W-1:0] a_scale_c, b_scale_c;
    logic [FRAC_W-1:0]         a_frac_c, b_frac_c;

    function automatic void decode_word(
        input  logic [NBITS-1:0]          w,
        output posit_class_e              cls,
        output logic                      sgn,
        output logic signed [SCALE_W-1:0] scale,
        output logic [FRAC_W-1:0]         frac
    );
        logic [NBITS-1:0]  mag;
        logic [NBITS-2:0]  body;
        logic [NBITS-2:0]  run;
        logic [NBITS-2:0]  rem;
        logic [5:0]        m;
        logic signed [5:0] k;
        // negative words are decoded from their magnitude
        mag  = w[NBITS-1] ? -w : w;
        body = mag[NBITS-2:0];
        // regime bits flipped to zeros, first one marks the terminator
        run  = body[NBITS-2] ? ~body : body;
        // all ones body has no terminator at all
        m = 6'd31;
        for (int i = 0; i < NBITS - 1; i++)
        begin
            if (run[i])
                m = 6'(NBITS - 2 - i);
        end
        // k = m-1 for a run of ones, k = -m for a run of zeros
        k = body[NBITS-2] ? $signed(m - 6'd1) : -$signed(m);
        // drop run and terminator, missing exponent bits come in as zeros
        rem = body << (m + 6'd1);
        scale = $signed({k, rem[NBITS-2 -: ES]});
        frac  = rem[NBITS-2-ES -: FRAC_W];
        sgn   = w[NBITS-1];
        if (w == ZERO_WORD)
            cls = CLASS_ZERO;
        else if (w == NAR_WORD)
            cls = CLASS_NAR;
        else
            cls = CLASS_NUM;
    endfunction

    always_comb
    begin
        decode_word(a, a_class_c, a_sign_c, a_scale_c, a_frac_c);
        decode_word(b, b_class_c, b_sign_c, b_scale_c, b_frac_c);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= in_valid;
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        a_class <= a_class_c;
        b_class <= b_class_c;
        a_sign  <= a_sign_c;
        b_sign  <= b_sign_c;
        a_scale <= a_scale_c;
        b_scale <= b_scale_c;
        a_frac  <= a_frac_c;
        b_frac  <= b_frac_c;
    end

    // real operands decode to a scale inside the posit range
    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && a_class == CLASS_NUM |-> a_scale <= MAX_SCALE && a_scale >= -MAX_SCALE);

    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && b_class == CLASS_NUM |-> b_scale <= MAX_SCALE && b_scale >= -MAX_SCALE);

endmodule

/* source/posit_pkg.sv */
// posit arithmetic definitions for the 32-bit adder with es = 3
// word widths, decoded field widths, operand class and special words
package posit_pkg;

    // word and exponent field
    localparam int NBITS = 32;
    localparam int ES = 3;

    // regime * 2^ES + exponent, signed
    localparam int SCALE_W = 9;

    // decoded fraction, hidden bit not included
    localparam int FRAC_W = 27;

    // raw sum: carry, hidden bit, fraction and one sticky slot
    localparam int SUM_W = 30;

    // largest regime is NBITS-2, so scale spans +-240
    localparam int MAX_SCALE = (NBITS - 2) * (1 << ES);

    // special words
    localparam logic [NBITS-1:0] NAR_WORD = {1'b1, {(NBITS - 1){1'b0}}};
    localparam logic [NBITS-1:0] ZERO_WORD = '0;

    // operand and result class
    typedef enum logic [1:0] {
        CLASS_ZERO = 2'd0,
        CLASS_NAR  = 2'd1,
        CLASS_NUM  = 2'd2
    } posit_class_e;

endpackage
